// File: compile.f
src/rv_pkg.sv
src/inst_fetch.sv
src/inst_decode.sv
src/reg_file.sv
src/alu.sv
src/branch_unit.sv
src/commit_unit.sv
src/rv_core.sv
verification/tb_checker.sv
verification/tb_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# runs once with the default reset PC and once with a nonzero one
run_one() {
    verilator --binary --timing --assert -f compile.f --top-module tb_top \
        -GRESET_PC="$1" --Mdir "$2" -o sim &&
    "./$2/sim" | tee /dev/stderr | grep "No errors" > /dev/null
}
run_one 0 obj_pc0 && run_one 512 obj_pc200 && echo "simulation passed" ||
    { echo "simulation failed"; exit 1; }

// File: src/alu.sv
`timescale 1ns/1ns

module alu (
    input  rv_pkg::ctrl_t ctrl,
    input  rv_pkg::word_t pc,
    input  rv_pkg::word_t rs1_data,
    input  rv_pkg::word_t rs2_data,
    input  rv_pkg::word_t imm,
    output rv_pkg::word_t result
);

    rv_pkg::word_t a;
    rv_pkg::word_t b;
    logic [4:0]    shamt;

    assign a     = (ctrl.a_sel == rv_pkg::A_PC) ? pc : rs1_data;
    assign b     = (ctrl.b_sel == rv_pkg::B_IMM) ? imm : rs2_data;
    assign shamt = b[4:0];

    always_comb begin
        case (ctrl.alu_op)
            rv_pkg::ALU_ADD:    result = a + b;
            rv_pkg::ALU_SUB:    result = a - b;
            rv_pkg::ALU_SLL:    result = a << shamt;
            rv_pkg::ALU_SLT:    result = {31'b0, $signed(a) < $signed(b)};
            rv_pkg::ALU_SLTU:   result = {31'b0, a < b};
            rv_pkg::ALU_XOR:    result = a ^ b;
            rv_pkg::ALU_SRL:    result = a >> shamt;
            rv_pkg::ALU_SRA:    result = $unsigned($signed(a) >>> shamt);
            rv_pkg::ALU_OR:     result = a | b;
            rv_pkg::ALU_AND:    result = a & b;
            rv_pkg::ALU_PASS_B: result = b;
            default:            result = '0;
        endcase
    end

endmodule

// File: src/branch_unit.sv
`timescale 1ns/1ns

module branch_unit (
    input  rv_pkg::ctrl_t ctrl,
    input  rv_pkg::word_t pc,
    input  rv_pkg::word_t rs1_data,
    input  rv_pkg::word_t rs2_data,
    input  rv_pkg::word_t imm,
    output logic          taken,
    output rv_pkg::word_t target
);

    logic cond;

    always_comb begin
        case (ctrl.funct3)
            3'b000:  cond = (rs1_data == rs2_data);                   // beq
            3'b001:  cond = (rs1_data != rs2_data);                   // bne
            3'b100:  cond = ($signed(rs1_data) < $signed(rs2_data));  // blt
            3'b101:  cond = ($signed(rs1_data) >= $signed(rs2_data)); // bge
            3'b110:  cond = (rs1_data < rs2_data);                    // bltu
            3'b111:  cond = (rs1_data >= rs2_data);                   // bgeu
            default: cond = 1'b0;
        endcase
    end

    assign taken  = ctrl.is_jal || ctrl.is_jalr || (ctrl.is_branch && cond);
    assign target = ctrl.is_jalr ? ((rs1_data + imm) & ~32'h1) : (pc + imm);

endmodule

// File: src/commit_unit.sv
`timescale 1ns/1ns

module commit_unit (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              inst_valid,
    output logic              inst_ready,
    input  rv_pkg::word_t     pc,
    input  rv_pkg::word_t     inst,
    input  rv_pkg::ctrl_t     ctrl,
    input  rv_pkg::word_t     alu_result,
    input  rv_pkg::word_t     rs2_data,
    input  rv_pkg::word_t     target,
    input  logic              taken,
    output rv_pkg::word_t     next_pc,
    output logic              rf_we,
    output rv_pkg::reg_addr_t rf_rd,
    output rv_pkg::word_t     rf_wdata,
    output logic              dmem_valid,
    output rv_pkg::mem_req_t  dmem_req,
    input  logic              dmem_ready,
    input  rv_pkg::word_t     dmem_rdata,
    output logic              retire_valid,
    output rv_pkg::retire_t   retire
);

    typedef enum logic {EXEC, MEM} state_e;

    state_e        state;
    logic          mem_op;
    rv_pkg::word_t pc_plus4;

    assign mem_op   = ctrl.is_load || ctrl.is_store;
    assign pc_plus4 = pc + 32'd4;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= EXEC;
        end else begin
            case (state)
                EXEC:    if (inst_valid && mem_op) state <= MEM;
                MEM:     if (dmem_ready) state <= EXEC;  // retire on handshake
                default: state <= EXEC;
            endcase
        end
    end

    assign inst_ready = (state == EXEC) ? (inst_valid && !mem_op) : dmem_ready;
    assign next_pc    = taken ? target : pc_plus4;

    // operands stay put while the instruction is held, so the request does too
    assign dmem_valid     = (state == MEM);
    assign dmem_req.addr  = alu_result;
    assign dmem_req.wdata = rs2_data;
    assign dmem_req.we    = ctrl.is_store;

    always_comb begin
        case (ctrl.wb_sel)
            rv_pkg::WB_ALU:  rf_wdata = alu_result;
            rv_pkg::WB_PC4:  rf_wdata = pc_plus4;
            rv_pkg::WB_LOAD: rf_wdata = dmem_rdata;
            default:         rf_wdata = '0;
        endcase
    end

    assign retire_valid = inst_valid && inst_ready;
    assign rf_we        = retire_valid && ctrl.wb_sel != rv_pkg::WB_NONE && ctrl.rd != '0;
    assign rf_rd        = ctrl.rd;

    assign retire.pc      = pc;
    assign retire.inst    = inst;
    assign retire.rd      = ctrl.rd;
    assign retire.rd_we   = rf_we;
    assign retire.rd_data = rf_we ? rf_wdata : '0;  // x0 shows as zero

    a_dmem_stable: assert property (@(posedge clk) disable iff (!rst_n)
        dmem_valid && !dmem_ready |=> dmem_valid && $stable(dmem_req));

    // fetch must drop the instruction once it has retired
    a_retire_handshake: assert property (@(posedge clk) disable iff (!rst_n)
        retire_valid |-> inst_ready ##1 !inst_valid);

endmodule

// File: src/inst_decode.sv
`timescale 1ns/1ns

module inst_decode (
    input  rv_pkg::word_t inst,
    output rv_pkg::ctrl_t ctrl,
    output rv_pkg::word_t imm
);

    rv_pkg::opcode_e opcode;
    rv_pkg::word_t   imm_i;
    rv_pkg::word_t   imm_s;
    rv_pkg::word_t   imm_b;
    rv_pkg::word_t   imm_u;
    rv_pkg::word_t   imm_j;
    logic            alt;  // sub / sra select

    function automatic rv_pkg::alu_op_e alu_op_of(input logic [2:0] f3, input logic alt_op);
        case (f3)
            3'b000:  return alt_op ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
            3'b001:  return rv_pkg::ALU_SLL;
            3'b010:  return rv_pkg::ALU_SLT;
            3'b011:  return rv_pkg::ALU_SLTU;
            3'b100:  return rv_pkg::ALU_XOR;
            3'b101:  return alt_op ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
            3'b110:  return rv_pkg::ALU_OR;
            default: return rv_pkg::ALU_AND;
        endcase
    endfunction

    assign opcode = rv_pkg::opcode_e'(inst[6:0]);

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'h000};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    // addi has no subtract form, srai shares bit 30 with sra
    assign alt = inst[30] && (opcode == rv_pkg::OPC_OP || inst[14:12] == 3'b101);

    always_comb begin
        ctrl.alu_op    = rv_pkg::ALU_ADD;
        ctrl.a_sel     = rv_pkg::A_RS1;
        ctrl.b_sel     = rv_pkg::B_IMM;
        ctrl.wb_sel    = rv_pkg::WB_NONE;
        ctrl.rd        = inst[11:7];
        ctrl.rs1       = inst[19:15];
        ctrl.rs2       = inst[24:20];
        ctrl.is_branch = 1'b0;
        ctrl.is_jal    = 1'b0;
        ctrl.is_jalr   = 1'b0;
        ctrl.is_load   = 1'b0;
        ctrl.is_store  = 1'b0;
        ctrl.funct3    = inst[14:12];
        imm            = imm_i;
        case (opcode)
            rv_pkg::OPC_LUI: begin
                ctrl.alu_op = rv_pkg::ALU_PASS_B;
                ctrl.wb_sel = rv_pkg::WB_ALU;
                imm         = imm_u;
            end
            rv_pkg::OPC_AUIPC: begin
                ctrl.a_sel  = rv_pkg::A_PC;
                ctrl.wb_sel = rv_pkg::WB_ALU;
                imm         = imm_u;
            end
            rv_pkg::OPC_JAL: begin
                ctrl.is_jal = 1'b1;
                ctrl.wb_sel = rv_pkg::WB_PC4;  // link
                imm         = imm_j;
            end
            rv_pkg::OPC_JALR: begin
                ctrl.is_jalr = 1'b1;
                ctrl.wb_sel  = rv_pkg::WB_PC4;
            end
            rv_pkg::OPC_BRANCH: begin
                ctrl.is_branch = 1'b1;
                imm            = imm_b;
            end
            rv_pkg::OPC_LOAD: begin
                ctrl.is_load = 1'b1;  // word only
                ctrl.wb_sel  = rv_pkg::WB_LOAD;
            end
            rv_pkg::OPC_STORE: begin
                ctrl.is_store = 1'b1;
                imm           = imm_s;
            end
            rv_pkg::OPC_OP_IMM: begin
                ctrl.alu_op = alu_op_of(inst[14:12], alt);
                ctrl.wb_sel = rv_pkg::WB_ALU;
            end
            rv_pkg::OPC_OP: begin
                ctrl.alu_op = alu_op_of(inst[14:12], alt);
                ctrl.b_sel  = rv_pkg::B_RS2;
                ctrl.wb_sel = rv_pkg::WB_ALU;
            end
            default: ;  // unknown opcode retires as a no-op
        endcase
    end

endmodule

// File: src/inst_fetch.sv
`timescale 1ns/1ns

module inst_fetch #(
    parameter rv_pkg::word_t RESET_PC = 32'h0000_0000
) (
    input  logic          clk,
    input  logic          rst_n,
    output logic          imem_valid,
    output rv_pkg::word_t imem_addr,
    input  logic          imem_ready,
    input  rv_pkg::word_t imem_rdata,
    output logic          inst_valid,
    input  logic          inst_ready,
    output rv_pkg::word_t pc,
    output rv_pkg::word_t inst,
    input  rv_pkg::word_t next_pc
);

    typedef enum logic {REQ, HOLD} state_e;

    state_e        state;
    logic          req_q;   // imem request pending
    rv_pkg::word_t pc_q;
    rv_pkg::word_t inst_q;  // captured instruction, no reset

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= REQ;
            req_q <= 1'b0;
            pc_q  <= RESET_PC;
        end else begin
            case (state)
                REQ: begin
                    if (!req_q) begin
                        req_q <= 1'b1;  // first request after reset
                    end else if (imem_ready) begin
                        req_q <= 1'b0;
                        state <= HOLD;
                    end
                end
                HOLD: begin
                    if (inst_ready) begin
                        pc_q  <= next_pc;
                        req_q <= 1'b1;  // next fetch right after retire
                        state <= REQ;
                    end
                end
                default: state <= REQ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == REQ && req_q && imem_ready) begin
            inst_q <= imem_rdata;
        end
    end

    assign imem_valid = (state == REQ) && req_q;
    assign imem_addr  = pc_q;
    assign inst_valid = (state == HOLD);
    assign pc         = pc_q;
    assign inst       = inst_q;

    // fetch address must not move under back-pressure
    a_imem_stable: assert property (@(posedge clk) disable iff (!rst_n)
        imem_valid && !imem_ready |=> imem_valid && $stable(imem_addr));

endmodule

// File: src/reg_file.sv
`timescale 1ns/1ns

module reg_file (
    input  logic              clk,
    input  logic              rst_n,
    input  rv_pkg::reg_addr_t rs1,
    input  rv_pkg::reg_addr_t rs2,
    output rv_pkg::word_t     rs1_data,
    output rv_pkg::word_t     rs2_data,
    input  logic              we,
    input  rv_pkg::reg_addr_t rd,
    input  rv_pkg::word_t     rd_data
);

    rv_pkg::word_t regs [32];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin  // x0 writes dropped
            regs[rd] <= rd_data;
        end
    end

    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// File: src/rv_core.sv
`timescale 1ns/1ns

module rv_core #(
    parameter rv_pkg::word_t RESET_PC = 32'h0000_0000
) (
    input  logic             clk,
    input  logic             rst_n,
    output logic             imem_valid,
    output rv_pkg::word_t    imem_addr,
    input  logic             imem_ready,
    input  rv_pkg::word_t    imem_rdata,
    output logic             dmem_valid,
    output rv_pkg::mem_req_t dmem_req,
    input  logic             dmem_ready,
    input  rv_pkg::word_t    dmem_rdata,
    output logic             retire_valid,
    output rv_pkg::retire_t  retire
);

    logic              inst_valid;
    logic              inst_ready;
    rv_pkg::word_t     pc;
    rv_pkg::word_t     inst;
    rv_pkg::word_t     next_pc;
    rv_pkg::ctrl_t     ctrl;
    rv_pkg::word_t     imm;
    rv_pkg::word_t     rs1_data;
    rv_pkg::word_t     rs2_data;
    rv_pkg::word_t     alu_result;
    logic              taken;
    rv_pkg::word_t     target;
    logic              rf_we;
    rv_pkg::reg_addr_t rf_rd;
    rv_pkg::word_t     rf_wdata;

    inst_fetch #(.RESET_PC(RESET_PC)) fetch0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .imem_valid (imem_valid),
        .imem_addr  (imem_addr),
        .imem_ready (imem_ready),
        .imem_rdata (imem_rdata),
        .inst_valid (inst_valid),
        .inst_ready (inst_ready),
        .pc         (pc),
        .inst       (inst),
        .next_pc    (next_pc)
    );

    inst_decode decode0 (.inst(inst), .ctrl(ctrl), .imm(imm));

    reg_file rf0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1      (ctrl.rs1),
        .rs2      (ctrl.rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .we       (rf_we),
        .rd       (rf_rd),
        .rd_data  (rf_wdata)
    );

    alu alu0 (
        .ctrl     (ctrl),
        .pc       (pc),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .imm      (imm),
        .result   (alu_result)
    );

    branch_unit bru0 (
        .ctrl     (ctrl),
        .pc       (pc),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .imm      (imm),
        .taken    (taken),
        .target   (target)
    );

    commit_unit commit0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .inst_valid   (inst_valid),
        .inst_ready   (inst_ready),
        .pc           (pc),
        .inst         (inst),
        .ctrl         (ctrl),
        .alu_result   (alu_result),
        .rs2_data     (rs2_data),
        .target       (target),
        .taken        (taken),
        .next_pc      (next_pc),
        .rf_we        (rf_we),
        .rf_rd        (rf_rd),
        .rf_wdata     (rf_wdata),
        .dmem_valid   (dmem_valid),
        .dmem_req     (dmem_req),
        .dmem_ready   (dmem_ready),
        .dmem_rdata   (dmem_rdata),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

endmodule

// File: src/rv_pkg.sv
package rv_pkg;

    typedef logic [31:0] word_t;      // data word, pc or byte address
    typedef logic [4:0]  reg_addr_t;  // register index

    // base opcodes handled by the core
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B  // lui
    } alu_op_e;

    typedef enum logic {A_RS1, A_PC} a_sel_e;
    typedef enum logic {B_RS2, B_IMM} b_sel_e;
    typedef enum logic [1:0] {WB_ALU, WB_PC4, WB_LOAD, WB_NONE} wb_sel_e;

    typedef struct packed {
        alu_op_e   alu_op;
        a_sel_e    a_sel;
        b_sel_e    b_sel;
        wb_sel_e   wb_sel;
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
        logic      is_branch;
        logic      is_jal;
        logic      is_jalr;
        logic      is_load;
        logic      is_store;
        logic [2:0] funct3;  // branch condition
    } ctrl_t;

    typedef struct packed {
        word_t addr;
        word_t wdata;
        logic  we;
    } mem_req_t;

    typedef struct packed {
        word_t     pc;
        word_t     inst;
        reg_addr_t rd;
        logic      rd_we;
        word_t     rd_data;
    } retire_t;

endpackage

// File: verification/tb_checker.sv
`timescale 1ns/1ns

module tb_checker #(
    parameter rv_pkg::word_t RESET_PC = 32'h0000_0000
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             imem_valid,
    input  rv_pkg::word_t    imem_addr,
    input  logic             imem_ready,
    input  rv_pkg::word_t    imem_rdata,
    input  logic             retire_valid,
    input  rv_pkg::retire_t  retire,
    input  logic             dmem_valid,
    input  rv_pkg::mem_req_t dmem_req,
    input  logic             dmem_ready,
    output int               errors,
    output int               retired,
    output logic             halted
);

    typedef struct packed {
        rv_pkg::word_t next_pc;
        logic          rd_we;
        rv_pkg::word_t rd_data;
        logic          st;
        rv_pkg::word_t st_addr;
        rv_pkg::word_t st_data;
    } exp_t;

    rv_pkg::word_t    regs [32];
    rv_pkg::word_t    ref_mem [rv_pkg::word_t];  // only written words
    rv_pkg::word_t    exp_pc;
    rv_pkg::mem_req_t held_req;
    logic             held;
    rv_pkg::word_t    held_addr;
    logic             held_fetch;
    rv_pkg::word_t    fetched;  // word handed over at the last fetch
    exp_t             e;

    // same pattern the data memory model starts with
    function automatic rv_pkg::word_t fill_word(input rv_pkg::word_t a);
        return (a * 32'h0001_0003) ^ 32'h3c3c_a5a5;
    endfunction

    function automatic rv_pkg::word_t op_result(input logic [2:0] f3, input logic alt,
                                                input rv_pkg::word_t a, input rv_pkg::word_t b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    return (a < b) ? 32'd1 : 32'd0;
            3'd4:    return a ^ b;
            3'd5:    return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    // executes one instruction on the model state
    function automatic exp_t ref_step(input rv_pkg::word_t pc, input rv_pkg::word_t inst);
        exp_t          r;
        logic          wb;
        logic          cond;
        rv_pkg::word_t val;
        rv_pkg::word_t a;
        rv_pkg::word_t b;
        rv_pkg::word_t im_i;
        logic [2:0]    f3;
        r    = '0;
        wb   = 1'b0;
        val  = '0;
        cond = 1'b0;
        f3   = inst[14:12];
        a    = regs[inst[19:15]];
        b    = regs[inst[24:20]];
        im_i = {{20{inst[31]}}, inst[31:20]};
        r.next_pc = pc + 4;
        case (inst[6:0])
            7'h37: begin wb = 1'b1; val = {inst[31:12], 12'h0}; end
            7'h17: begin wb = 1'b1; val = pc + {inst[31:12], 12'h0}; end
            7'h6f: begin
                wb = 1'b1;
                val = pc + 4;
                r.next_pc = pc + {{11{inst[31]}}, inst[31], inst[19:12], inst[20],
                                  inst[30:21], 1'b0};
            end
            7'h67: begin
                wb = 1'b1;
                val = pc + 4;
                r.next_pc = (a + im_i) & ~32'h1;
            end
            7'h63: begin
                case (f3)
                    3'd0: cond = a == b;
                    3'd1: cond = a != b;
                    3'd4: cond = $signed(a) < $signed(b);
                    3'd5: cond = $signed(a) >= $signed(b);
                    3'd6: cond = a < b;
                    3'd7: cond = a >= b;
                    default: cond = 1'b0;
                endcase
                if (cond) begin
                    r.next_pc = pc + {{19{inst[31]}}, inst[31], inst[7], inst[30:25],
                                      inst[11:8], 1'b0};
                end
            end
            7'h03: begin
                wb = 1'b1;
                val = ref_mem.exists(a + im_i) ? ref_mem[a + im_i] : fill_word(a + im_i);
            end
            7'h23: begin
                r.st = 1'b1;
                r.st_addr = a + {{20{inst[31]}}, inst[31:25], inst[11:7]};
                r.st_data = b;
                ref_mem[r.st_addr] = b;
            end
            7'h13: val = op_result(f3, inst[30] && f3 == 3'd5, a, im_i);
            7'h33: val = op_result(f3, inst[30], a, b);
            default: ;  // no-op
        endcase
        wb = wb || inst[6:0] == 7'h13 || inst[6:0] == 7'h33;
        if (wb && inst[11:7] != 5'd0) begin
            r.rd_we = 1'b1;
            r.rd_data = val;
            regs[inst[11:7]] = val;
        end
        return r;
    endfunction

    task automatic check_word(input string name, input rv_pkg::word_t exp_v,
                              input rv_pkg::word_t act_v);
        if (exp_v !== act_v) begin
            $display("FAILED %s: expected %h, actual %h", name, exp_v, act_v);
            errors++;
        end
    endtask

    initial errors = 0;

    always @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] = '0;
            end
            ref_mem.delete();
            exp_pc     = RESET_PC;
            retired    = 0;
            halted     = 1'b0;
            held       = 1'b0;
            held_fetch = 1'b0;
            fetched    = '0;
        end else begin
            if (held_fetch && (!imem_valid || imem_addr !== held_addr)) begin
                $display("fetch request changed while the port was stalled");
                errors++;
            end
            held_fetch = imem_valid && !imem_ready;
            held_addr  = imem_addr;
            if (imem_valid && imem_ready) begin
                check_word("imem_addr", exp_pc, imem_addr);
                fetched = imem_rdata;
            end
            if (held && (!dmem_valid || dmem_req !== held_req)) begin
                $display("data request changed while the port was stalled");
                errors++;
            end
            held     = dmem_valid && !dmem_ready;
            held_req = dmem_req;
            if (retire_valid) begin
                e = ref_step(exp_pc, fetched);
                check_word("pc", exp_pc, retire.pc);
                check_word("inst", fetched, retire.inst);
                check_word("rd_we", 32'(e.rd_we), 32'(retire.rd_we));
                check_word("rd", 32'(fetched[11:7]), 32'(retire.rd));
                check_word("rd_data", e.rd_data, retire.rd_data);
                if (e.st) begin
                    if (!(dmem_valid && dmem_ready && dmem_req.we)) begin
                        $display("store retired without a data-port write");
                        errors++;
                    end
                    check_word("dmem_req.addr", e.st_addr, dmem_req.addr);
                    check_word("dmem_req.wdata", e.st_data, dmem_req.wdata);
                end
                exp_pc = e.next_pc;
                retired++;
                if (retire.inst == 32'h0000_006f) begin
                    halted = 1'b1;  // jal x0, 0
                end
            end
        end
    end

endmodule

// File: verification/tb_top.sv
`timescale 1ns/1ns

module tb_top #(
    parameter rv_pkg::word_t RESET_PC = 32'h0000_0000
);

    logic             clk = 1'b0;
    logic             rst_n;
    logic             imem_valid;
    rv_pkg::word_t    imem_addr;
    logic             imem_ready;
    rv_pkg::word_t    imem_rdata;
    logic             dmem_valid;
    rv_pkg::mem_req_t dmem_req;
    logic             dmem_ready;
    rv_pkg::word_t    dmem_rdata;
    logic             retire_valid;
    rv_pkg::retire_t  retire;
    int               errors;
    int               retired;
    logic             halted;
    logic             stall_en;
    rv_pkg::word_t    imem [1024];
    rv_pkg::word_t    dmem [1024];
    rv_pkg::word_t    prog [$];
    int               cyc = 0;
    int               limit = 0;
    int               failed_tests = 0;
    int               err_before;

    always #4 clk = ~clk;

    rv_core #(.RESET_PC(RESET_PC)) dut0 (.*);

    tb_checker #(.RESET_PC(RESET_PC)) chk0 (.*);

    assign imem_rdata = imem[imem_addr[11:2]];
    assign dmem_rdata = dmem[dmem_req.addr[11:2]];

    always @(posedge clk) begin
        cyc <= cyc + 1;
        imem_ready <= !stall_en || ($urandom % 4 != 0);
        dmem_ready <= !stall_en || ($urandom % 3 != 0);
        if (!rst_n) begin
            for (int i = 0; i < 1024; i++) begin
                dmem[i] <= ((i << 2) * 32'h0001_0003) ^ 32'h3c3c_a5a5;
            end
        end else if (dmem_valid && dmem_ready && dmem_req.we) begin
            dmem[dmem_req.addr[11:2]] <= dmem_req.wdata;
        end
    end

    function automatic rv_pkg::word_t enc_r(input logic [6:0] f7, input int rs2, input int rs1,
                                            input logic [2:0] f3, input int rd);
        return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), 7'h33};
    endfunction

    function automatic rv_pkg::word_t enc_i(input logic [11:0] imm, input int rs1,
                                            input logic [2:0] f3, input int rd,
                                            input logic [6:0] op);
        return {imm, 5'(rs1), f3, 5'(rd), op};
    endfunction

    function automatic rv_pkg::word_t enc_s(input logic [11:0] imm, input int rs2, input int rs1);
        return {imm[11:5], 5'(rs2), 5'(rs1), 3'd2, imm[4:0], 7'h23};
    endfunction

    function automatic rv_pkg::word_t enc_b(input logic [12:0] off, input int rs2, input int rs1,
                                            input logic [2:0] f3);
        return {off[12], off[10:5], 5'(rs2), 5'(rs1), f3, off[4:1], off[11], 7'h63};
    endfunction

    function automatic rv_pkg::word_t enc_j(input logic [20:0] off, input int rd);
        return {off[20], off[10:1], off[11], off[19:12], 5'(rd), 7'h6f};
    endfunction

    task automatic build_alu();
        logic [11:0] imm;
        for (int r = 1; r <= 8; r++) begin
            prog.push_back({20'($urandom), 5'(r), 7'h37});
            prog.push_back(enc_i(12'($urandom), r, 3'd0, r, 7'h13));
        end
        for (int f3 = 0; f3 < 8; f3++) begin
            for (int alt = 0; alt < 2; alt++) begin
                if (alt == 0 || f3 == 0 || f3 == 5) begin
                    prog.push_back(enc_r(alt ? 7'h20 : 7'h00, $urandom % 8 + 1,
                                         $urandom % 8 + 1, 3'(f3), $urandom % 12));
                end
                if (alt == 0 || f3 == 5) begin
                    imm = (f3 == 1 || f3 == 5) ? {alt ? 7'h20 : 7'h00, 5'($urandom)}
                                               : 12'($urandom);
                    prog.push_back(enc_i(imm, $urandom % 8 + 1, 3'(f3), $urandom % 12, 7'h13));
                end
            end
        end
        prog.push_back(enc_i(12'd7, 1, 3'd0, 0, 7'h13));  // write to x0
        prog.push_back(enc_r(7'h00, 0, 0, 3'd0, 11));      // x0 reads zero
        prog.push_back({20'($urandom), 5'd12, 7'h17});     // auipc
    endtask

    task automatic build_branch();
        int pairs [3][2] = '{'{1, 3}, '{1, 2}, '{2, 1}};
        int conds [6] = '{0, 1, 4, 5, 6, 7};
        prog.push_back(enc_i(12'd5, 0, 3'd0, 1, 7'h13));
        prog.push_back(enc_i(-12'sd3, 0, 3'd0, 2, 7'h13));
        prog.push_back(enc_i(12'd5, 0, 3'd0, 3, 7'h13));
        foreach (conds[c]) begin
            foreach (pairs[p]) begin
                prog.push_back(enc_b(13'd8, pairs[p][1], pairs[p][0], 3'(conds[c])));
                prog.push_back(enc_i(12'd1, 10, 3'd0, 10, 7'h13));  // skipped when taken
            end
        end
        prog.push_back(enc_j(21'd8, 5));
        prog.push_back(enc_i(12'd1, 10, 3'd0, 10, 7'h13));
        prog.push_back({20'd0, 5'd6, 7'h17});               // auipc x6, 0
        prog.push_back(enc_i(12'd13, 6, 3'd0, 7, 7'h67));   // odd offset, bit 0 dropped
        prog.push_back(enc_i(12'd1, 10, 3'd0, 10, 7'h13));
        prog.push_back(enc_r(7'h00, 7, 5, 3'd0, 11));
    endtask

    task automatic build_ls();
        prog.push_back(enc_i(12'h100, 0, 3'd0, 1, 7'h13));
        for (int k = 0; k < 4; k++) begin
            prog.push_back({20'($urandom), 5'd2, 7'h37});
            prog.push_back(enc_i(12'($urandom), 2, 3'd0, 2, 7'h13));
            prog.push_back(enc_s(12'(k * 4), 2, 1));
        end
        prog.push_back(enc_i(12'd0, 1, 3'd2, 4, 7'h03));
        prog.push_back(enc_i(12'd8, 1, 3'd2, 5, 7'h03));
        prog.push_back(enc_i(12'd16, 1, 3'd2, 6, 7'h03));   // never written
        prog.push_back(enc_i(-12'sd4, 1, 3'd2, 7, 7'h03));
        prog.push_back(enc_s(12'd20, 4, 1));
        prog.push_back(enc_i(12'd20, 1, 3'd2, 8, 7'h03));
        prog.push_back(enc_i(12'd4, 1, 3'd2, 0, 7'h03));    // load into x0
    endtask

    task automatic run_prog(input int num, input string name, input logic stall);
        prog.push_back(enc_j(21'd0, 0));  // halt loop
        @(posedge clk);
        rst_n    <= 1'b0;
        stall_en <= stall;
        for (int i = 0; i < 1024; i++) begin
            imem[i] = '0;
        end
        foreach (prog[i]) begin
            imem[RESET_PC[11:2] + i] = prog[i];
        end
        limit      = limit + prog.size() * 40;
        err_before = errors;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        do begin
            @(negedge clk);
        end while (!halted && cyc < limit);
        if (!halted) begin
            $display("timeout in test %0d %s, no halt retirement after %0d cycles",
                     num, name, cyc);
            $display("Errors found");
            $finish;
        end
        if (errors != err_before) begin
            failed_tests++;
        end
        $display("test %0d %s: %0d retired, %0d errors", num, name, retired,
                 errors - err_before);
    endtask

    initial begin
        rst_n      = 1'b0;
        stall_en   = 1'b0;
        imem_ready = 1'b0;
        dmem_ready = 1'b0;
        void'($urandom(32'h0a32_8886));
        prog.delete();
        prog.push_back(enc_i(12'd5, 0, 3'd0, 1, 7'h13));
        run_prog(1, "reset_pc", 1'b0);
        prog.delete();
        build_alu();
        run_prog(2, "alu", 1'b0);
        prog.delete();
        build_branch();
        run_prog(3, "branch_jump", 1'b0);
        prog.delete();
        build_ls();
        run_prog(4, "load_store", 1'b0);
        prog.delete();
        build_alu();
        build_branch();
        build_ls();
        run_prog(5, "stalls", 1'b1);
        $display("summary: 5 tests, %0d failed, %0d errors", failed_tests, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule
